// File: design/booth_digit_sel.sv
// Radix-4 Booth selector, one instance per partial-product row in the first stage
`timescale 1ns/1ps

module booth_digit_sel (
	input  logic [2:0]         bits,
	input  booth_pkg::opnd_t   mcand,
	output booth_pkg::pp_row_t row,
	output logic               neg
);
	import booth_pkg::*;

	pp_row_t mc_ext;
	pp_row_t mag;
	logic    one;
	logic    two;

	assign mc_ext = {{(PROD_W-OPND_W){mcand[OPND_W-1]}}, mcand};  // Sign extend to row width

	assign one = bits[1] ^ bits[0];                    // Digit magnitude 1
	assign two = (bits == 3'b011) || (bits == 3'b100); // Digit magnitude 2
	assign neg = bits[2] & ~(bits[1] & bits[0]);       // 111 is zero, not negative

	always_comb begin
		if (one)
			mag = mc_ext;
		else if (two)
			mag = mc_ext << 1;
		else
			mag = '0;
	end

	// One's complement only, the +1 is added in the reducer
	assign row = neg ? ~mag : mag;

endmodule

// File: design/booth_pkg.sv
// Internal datapath sizes and row types of the Booth multiplier, imported by the RTL stages
package booth_pkg;

	// ============================================================
	// Datapath sizes
	// ============================================================
	localparam int OPND_W     = mul_pkg::XLEN + 2;  // Two extra sign bits
	localparam int PP_ROWS    = OPND_W / 2;         // One row per radix-4 digit
	localparam int PROD_W     = 2 * OPND_W;         // Full width of a row
	localparam int CSA_ROWS   = PP_ROWS + 1;        // Plus the negation row
	localparam int CSA_LEVELS = 8;                  // 3:2 layers from 34 rows to 2

	// ============================================================
	// Types
	// ============================================================
	typedef logic [OPND_W-1:0] opnd_t;
	typedef logic [PROD_W-1:0] pp_row_t;

	// Row PP_ROWS holds the +1 of every negated Booth row
	typedef pp_row_t [CSA_ROWS-1:0] pp_array_t;

endpackage

// File: design/booth_stage.sv
// First multiplier stage: operand extension, Booth rows, stage 1 register and ready logic
`timescale 1ns/1ps

module booth_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 mul_valid,
	input  mul_pkg::xlen_t       multiplicand,
	input  mul_pkg::xlen_t       multiplier,
	input  mul_pkg::mul_sign_e   mul_signed,
	input  logic                 mulw,
	input  logic                 s2_valid,
	output logic                 mul_ready,
	output booth_pkg::pp_array_t pp_rows,
	output logic                 s1_valid
);
	import mul_pkg::*;
	import booth_pkg::*;

	logic               a_signed;
	logic               b_signed;
	xlen_t              a_src;
	xlen_t              b_src;
	opnd_t              mcand_ext;
	opnd_t              mplier_ext;
	logic [OPND_W:0]    mplier_pad;
	pp_row_t            raw_row [PP_ROWS];
	logic [PP_ROWS-1:0] neg_bits;
	pp_row_t            neg_row;
	pp_array_t          pp_next;
	logic               accept;

	// ============================================================
	// Operand extension
	// ============================================================
	assign a_signed = (mul_signed == MUL_SU) || (mul_signed == MUL_SS);
	assign b_signed = (mul_signed == MUL_US) || (mul_signed == MUL_SS);

	assign a_src = mulw ?
		{{(XLEN-WORD_W){a_signed & multiplicand[WORD_W-1]}}, multiplicand[WORD_W-1:0]} :
		multiplicand;
	assign b_src = mulw ?
		{{(XLEN-WORD_W){b_signed & multiplier[WORD_W-1]}}, multiplier[WORD_W-1:0]} :
		multiplier;

	assign mcand_ext  = {{(OPND_W-XLEN){a_signed & a_src[XLEN-1]}}, a_src};
	assign mplier_ext = {{(OPND_W-XLEN){b_signed & b_src[XLEN-1]}}, b_src};
	assign mplier_pad = {mplier_ext, 1'b0};         // Implicit zero below bit 0

	// ============================================================
	// Booth rows
	// ============================================================
	for (genvar i = 0; i < PP_ROWS; i++) begin : g_row
		booth_digit_sel u_booth_digit_sel (
			.bits  (mplier_pad[2*i +: 3]),
			.mcand (mcand_ext),
			.row   (raw_row[i]),
			.neg   (neg_bits[i])
		);
	end

	always_comb begin
		neg_row = '0;
		for (int k = 0; k < PP_ROWS; k++) begin
			pp_next[k]     = raw_row[k] << (2 * k);  // Weight 4^k
			neg_row[2 * k] = neg_bits[k];            // +1 lands at the row's LSB
		end
		pp_next[PP_ROWS] = neg_row;
	end

	// ============================================================
	// Stage 1 register
	// ============================================================
	assign mul_ready = ~(s1_valid | s2_valid);  // One operation in flight
	assign accept    = mul_valid & mul_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= accept & ~flush;        // Accept with flush is dropped
	end

	always_ff @(posedge clk) begin
		if (accept)
			pp_rows <= pp_next;
	end

	// Stage 2 stays empty on the cycle after accept
	a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
		accept |=> !s2_valid)
		else $error("accept overlaps an operation in stage 2");

endmodule

// File: design/compress_stage.sv
// Second multiplier stage: CSA reduction, stage 2 register, final adder and result split
`timescale 1ns/1ps

module compress_stage (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 flush,
	input  logic                 s1_valid,
	input  booth_pkg::pp_array_t pp_rows,
	output logic                 s2_valid,
	output logic                 out_valid,
	output mul_pkg::xlen_t       result_hi,
	output mul_pkg::xlen_t       result_lo
);
	import mul_pkg::*;
	import booth_pkg::*;

	pp_row_t sum_vec;
	pp_row_t carry_vec;
	pp_row_t sum_q;
	pp_row_t carry_q;
	pp_row_t product;

	csa_reducer u_csa_reducer (
		.rows      (pp_rows),
		.sum_vec   (sum_vec),
		.carry_vec (carry_vec)
	);

	// ============================================================
	// Stage 2 register
	// ============================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid & ~flush;
	end

	always_ff @(posedge clk) begin
		if (s1_valid && !flush) begin   // Hold last result otherwise
			sum_q   <= sum_vec;
			carry_q <= carry_vec;
		end
	end

	// ============================================================
	// Final adder
	// ============================================================
	assign product   = sum_q + carry_q;
	assign result_hi = product[2*XLEN-1:XLEN];
	assign result_lo = product[XLEN-1:0];
	assign out_valid = s2_valid;

	a_out_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |=> !out_valid)
		else $error("out_valid held for more than one cycle");

	// The rows loaded in stage 1 must reach the output as a known product
	a_out_follows: assert property (@(posedge clk) disable iff (!arst_n)
		(s1_valid && !flush) |-> ##(MUL_LATENCY-1) (out_valid && !$isunknown(product)))
		else $error("out_valid missing or product unknown after stage 1");

endmodule

// File: design/csa_reducer.sv
// Layered 3:2 carry-save tree reducing all Booth rows to a sum and a carry vector
`timescale 1ns/1ps

module csa_reducer (
	input  booth_pkg::pp_array_t rows,
	output booth_pkg::pp_row_t   sum_vec,
	output booth_pkg::pp_row_t   carry_vec
);
	import booth_pkg::*;

	// Rows left after a given number of 3:2 layers
	function automatic int rows_at(input int level);
		int n;
		n = CSA_ROWS;
		for (int k = 0; k < level; k++)
			n = (n / 3) * 2 + n % 3;
		return n;
	endfunction

	pp_array_t lvl [CSA_LEVELS+1];

	assign lvl[0] = rows;

	// ============================================================
	// Reduction layers
	// ============================================================
	for (genvar l = 0; l < CSA_LEVELS; l++) begin : g_level
		localparam int N_IN  = rows_at(l);
		localparam int N_GRP = N_IN / 3;
		localparam int N_OUT = rows_at(l + 1);

		for (genvar g = 0; g < N_GRP; g++) begin : g_csa
			pp_row_t a;
			pp_row_t b;
			pp_row_t c;

			assign a = lvl[l][3*g];
			assign b = lvl[l][3*g+1];
			assign c = lvl[l][3*g+2];

			assign lvl[l+1][2*g]   = a ^ b ^ c;                         // Sum
			assign lvl[l+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1; // Carry, one place up
		end

		// Rows that do not fill a group move down unchanged
		for (genvar r = 0; r < N_IN - 3 * N_GRP; r++) begin : g_pass
			assign lvl[l+1][2*N_GRP+r] = lvl[l][3*N_GRP+r];
		end

		for (genvar z = N_OUT; z < CSA_ROWS; z++) begin : g_zero
			assign lvl[l+1][z] = '0;  // Unused slots
		end
	end

	assign sum_vec   = lvl[CSA_LEVELS][0];
	assign carry_vec = lvl[CSA_LEVELS][1];

endmodule

// File: design/mul_pkg.sv
// Interface-level sizes and types of the multiplier, imported by the RTL and the testbench
package mul_pkg;

	// ============================================================
	// Operand sizes
	// ============================================================
	localparam int XLEN   = 64;                 // Operand and result half width
	localparam int WORD_W = 32;                 // Operand width in word mode

	localparam int MUL_LATENCY = 2;             // Accept edge to out_valid

	typedef logic [XLEN-1:0] xlen_t;

	// ============================================================
	// Sign mode
	// ============================================================
	// Bit 0 marks the multiplicand signed, bit 1 the multiplier
	typedef enum logic [1:0] {
		MUL_UU = 2'b00,                         // Both unsigned
		MUL_SU = 2'b01,                         // Signed multiplicand
		MUL_US = 2'b10,                         // Signed multiplier
		MUL_SS = 2'b11                          // Both signed
	} mul_sign_e;

endpackage

// File: design/multiplier_top.sv
// Top level of the pipelined Booth multiplier, instantiated by the execute stage or testbench
`timescale 1ns/1ps

module multiplier_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               flush,
	input  logic               mul_valid,
	input  logic               mulw,
	input  mul_pkg::mul_sign_e mul_signed,
	input  mul_pkg::xlen_t     multiplicand,
	input  mul_pkg::xlen_t     multiplier,
	output logic               mul_ready,
	output logic               out_valid,
	output mul_pkg::xlen_t     result_hi,
	output mul_pkg::xlen_t     result_lo
);
	import booth_pkg::*;

	pp_array_t pp_rows;   // Registered Booth rows
	logic      s1_valid;
	logic      s2_valid;

	// ============================================================
	// Stage 1
	// ============================================================
	booth_stage u_booth_stage (
		.clk          (clk),
		.arst_n       (arst_n),
		.flush        (flush),
		.mul_valid    (mul_valid),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_signed   (mul_signed),
		.mulw         (mulw),
		.s2_valid     (s2_valid),
		.mul_ready    (mul_ready),
		.pp_rows      (pp_rows),
		.s1_valid     (s1_valid)
	);

	// ============================================================
	// Stage 2
	// ============================================================
	compress_stage u_compress_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.flush     (flush),
		.s1_valid  (s1_valid),
		.pp_rows   (pp_rows),
		.s2_valid  (s2_valid),
		.out_valid (out_valid),
		.result_hi (result_hi),
		.result_lo (result_lo)
	);

endmodule

// File: files.f
+incdir+include
design/mul_pkg.sv
design/booth_pkg.sv
design/booth_digit_sel.sv
design/booth_stage.sv
design/csa_reducer.sv
design/compress_stage.sv
design/multiplier_top.sv
tb/tb_multiplier.sv

// File: include/mul_vectors.svh
// Directed multiplier stimulus table, included into the testbench module body
`ifndef MUL_VECTORS_SVH
`define MUL_VECTORS_SVH

typedef struct packed {
	logic [63:0]        a;      // Multiplicand
	logic [63:0]        b;      // Multiplier
	mul_pkg::mul_sign_e mode;
	logic               w;      // Word mode
} mul_vec_t;

localparam int NUM_VECTORS = 12;

localparam mul_vec_t MUL_VECTORS [NUM_VECTORS] = '{
	'{64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, mul_pkg::MUL_UU, 1'b0},
	'{64'h0000_0000_0000_0000, 64'h1234_5678_9ABC_DEF0, mul_pkg::MUL_UU, 1'b0},
	'{64'h0000_0000_0000_0001, 64'hDEAD_BEEF_CAFE_F00D, mul_pkg::MUL_UU, 1'b0},
	'{64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, mul_pkg::MUL_SS, 1'b0},
	'{64'hFFFF_FFFF_FFFF_FFFF, 64'h7FFF_FFFF_FFFF_FFFF, mul_pkg::MUL_SS, 1'b0},
	'{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, mul_pkg::MUL_SU, 1'b0},
	'{64'hFFFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000, mul_pkg::MUL_US, 1'b0},
	'{64'h1234_5678_9ABC_DEF0, 64'hFEDC_BA98_7654_3210, mul_pkg::MUL_SS, 1'b0},
	'{64'hDEAD_BEEF_8000_0000, 64'hCAFE_F00D_FFFF_FFFF, mul_pkg::MUL_SS, 1'b1},
	'{64'hABCD_0000_FFFF_FFFF, 64'h1111_2222_FFFF_FFFF, mul_pkg::MUL_UU, 1'b1},
	'{64'h5555_5555_8000_0001, 64'hAAAA_AAAA_7FFF_FFFF, mul_pkg::MUL_SU, 1'b1},
	'{64'h0123_4567_89AB_CDEF, 64'hFFFF_0000_8000_0000, mul_pkg::MUL_US, 1'b1}
};

`endif

// File: tb/tb_multiplier.sv
// Self-checking testbench for the pipelined Booth multiplier, compiled with files.f
`timescale 1ns/1ps

module tb_multiplier;
	import mul_pkg::*;

	`include "mul_vectors.svh"

	localparam int NUM_RANDOM  = 200;
	localparam int MAX_WAIT    = 10;                                  // Cycles to wait for out_valid
	localparam int WATCHDOG_NS = (NUM_VECTORS + NUM_RANDOM) * 6 * 8 + 4 * 8;

	logic      clk;
	logic      arst_n;
	logic      flush;
	logic      mul_valid;
	logic      mulw;
	mul_sign_e mul_signed;
	xlen_t     multiplicand;
	xlen_t     multiplier;
	logic      mul_ready;
	logic      out_valid;
	xlen_t     result_hi;
	xlen_t     result_lo;

	int        errors;
	int        tests;
	int        failed_tests;
	integer    seed;

	multiplier_top u_multiplier_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.flush        (flush),
		.mul_valid    (mul_valid),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	always #4 clk = ~clk;

	// ============================================================
	// Reference model and compare tasks
	// ============================================================
	function automatic logic [2*XLEN-1:0] model_product(input xlen_t a, input xlen_t b,
			input mul_sign_e mode, input logic w);
		logic                sa;
		logic                sb;
		logic signed [131:0] va;
		logic signed [131:0] vb;
		logic signed [131:0] p;
		sa = (mode == MUL_SU) || (mode == MUL_SS);
		sb = (mode == MUL_US) || (mode == MUL_SS);
		if (w) begin
			va = sa ? 132'($signed(a[WORD_W-1:0])) : 132'(a[WORD_W-1:0]);
			vb = sb ? 132'($signed(b[WORD_W-1:0])) : 132'(b[WORD_W-1:0]);
		end else begin
			va = sa ? 132'($signed(a)) : 132'(a);
			vb = sb ? 132'($signed(b)) : 132'(b);
		end
		p = va * vb;                                    // Integer value of the product
		return p[2*XLEN-1:0];
	endfunction

	task automatic check_half(input string name, input xlen_t expected, input xlen_t actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %h actual %h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input bit expected, input logic actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s expected %b actual %b",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string label, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests, label);
		end else begin
			failed_tests++;
			$display("test %0d %s: wrong", tests, label);
		end
	endtask

	// ============================================================
	// Operation sequences
	// ============================================================
	task automatic run_op(input string label, input xlen_t a, input xlen_t b,
			input mul_sign_e mode, input logic w);
		int                errs_before;
		int                cycles;
		bit                seen;
		logic [2*XLEN-1:0] expected;
		errs_before = errors;
		expected    = model_product(a, b, mode, w);
		cycles      = 0;
		seen        = 0;
		@(negedge clk);
		multiplicand = a;
		multiplier   = b;
		mul_signed   = mode;
		mulw         = w;
		mul_valid    = 1'b1;
		check_flag("mul_ready", 1'b1, mul_ready);
		@(posedge clk);                               // Accept edge
		while (!seen && cycles < MAX_WAIT) begin
			@(negedge clk);
			cycles++;
			if (out_valid === 1'b1) begin
				seen      = 1;
				mul_valid = 1'b0;
			end else begin
				check_flag("mul_ready", 1'b0, mul_ready);
				multiplicand = ~a;                    // Request while busy is ignored
				multiplier   = ~b;
			end
		end
		mul_valid = 1'b0;
		if (!seen) begin
			$display("out_valid never arrived within %0d cycles for %s", MAX_WAIT, label);
			errors++;
		end else begin
			if (cycles != MUL_LATENCY) begin
				$display("mismatch at %0t ns: out_valid latency expected %0d actual %0d",
					$time, MUL_LATENCY, cycles);
				errors++;
			end
			check_half("result_hi", expected[2*XLEN-1:XLEN], result_hi);
			check_half("result_lo", expected[XLEN-1:0], result_lo);
			check_flag("mul_ready", 1'b0, mul_ready);
			@(negedge clk);
			check_flag("out_valid", 1'b0, out_valid); // Single-cycle pulse
			check_flag("mul_ready", 1'b1, mul_ready);
		end
		report_test(label, errs_before);
	endtask

	task automatic run_flush(input xlen_t a, input xlen_t b);
		int errs_before;
		errs_before = errors;
		@(negedge clk);
		multiplicand = a;
		multiplier   = b;
		mul_signed   = MUL_SS;
		mulw         = 1'b0;
		mul_valid    = 1'b1;
		@(negedge clk);
		check_flag("mul_ready", 1'b0, mul_ready);     // Operation in stage 1
		mul_valid = 1'b0;
		flush     = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		check_flag("mul_ready", 1'b1, mul_ready);
		check_flag("out_valid", 1'b0, out_valid);
		repeat (MUL_LATENCY + 1) begin
			@(negedge clk);
			check_flag("out_valid", 1'b0, out_valid);
		end
		report_test("flush", errs_before);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int         errs_before;
		xlen_t      ra;
		xlen_t      rb;
		logic [1:0] rmode;
		logic       rw;
		clk          = 1'b0;
		arst_n       = 1'b0;
		flush        = 1'b0;
		mul_valid    = 1'b0;
		mulw         = 1'b0;
		mul_signed   = MUL_UU;
		multiplicand = '0;
		multiplier   = '0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		seed         = 18505;
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		errs_before = errors;
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("mul_ready", 1'b1, mul_ready);
		report_test("after reset", errs_before);

		for (int i = 0; i < NUM_VECTORS; i++)
			run_op($sformatf("vector %0d", i), MUL_VECTORS[i].a, MUL_VECTORS[i].b,
				MUL_VECTORS[i].mode, MUL_VECTORS[i].w);

		run_flush(64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210);
		run_op("after flush", 64'h0000_0000_0000_0007, 64'hFFFF_FFFF_FFFF_FFFD, MUL_SS, 1'b0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			ra    = {$random(seed), $random(seed)};
			rb    = {$random(seed), $random(seed)};
			rmode = 2'($random(seed));
			rw    = 1'($random(seed));
			run_op($sformatf("random %0d", i), ra, rb, mul_sign_e'(rmode), rw);
		end

		$display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Budget of six cycles per operation plus reset
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule
